//--- hw/mips_pkg.sv
//--------------------------------------------------
// mips package
// instruction formats, opcode/funct/alu codes and
// memory sizes for the single-cycle core
//--------------------------------------------------
package mips_pkg;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fmt_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i_fmt_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] target;
	} j_fmt_t;

	// one fetched word, three ways to read it
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		j_fmt_t j;
	} instr_t;

	localparam logic [5:0] OP_RTYPE = 6'b000000;
	localparam logic [5:0] OP_LW    = 6'b100011;
	localparam logic [5:0] OP_SW    = 6'b101011;
	localparam logic [5:0] OP_BEQ   = 6'b000100;
	localparam logic [5:0] OP_ADDI  = 6'b001000;
	localparam logic [5:0] OP_J     = 6'b000010;

	localparam logic [5:0] FN_ADD = 6'b100000;
	localparam logic [5:0] FN_SUB = 6'b100010;
	localparam logic [5:0] FN_AND = 6'b100100;
	localparam logic [5:0] FN_OR  = 6'b100101;
	localparam logic [5:0] FN_SLT = 6'b101010;

	typedef enum logic [1:0] {
		ALU_MEM   = 2'b00, // add, address calc
		ALU_BEQ   = 2'b01, // subtract for compare
		ALU_ARITH = 2'b10  // look at funct
	} alu_op_t;

	localparam int IMEM_WORDS = 64;
	localparam int DMEM_WORDS = 64;
	localparam int IMEM_AW    = 6;
	localparam int DMEM_AW    = 6;

endpackage

//--- hw/ctrl_if.sv
//--------------------------------------------------
// control bus
// decoded steering signals from decoder to datapath
//--------------------------------------------------
interface ctrl_if;
	mips_pkg::alu_op_t alu_op;
	logic mem_toreg;
	logic mem_write;
	logic mem_read;
	logic branch;
	logic alu_src;
	logic reg_dst;
	logic reg_write;
	logic jump;
	logic illegal; // opcode not in the supported set

	modport decoder (output alu_op, mem_toreg, mem_write, mem_read, branch,
		alu_src, reg_dst, reg_write, jump, illegal);

	modport datapath (input alu_op, mem_toreg, mem_write, mem_read, branch,
		alu_src, reg_dst, reg_write, jump, illegal);
endinterface

//--- hw/control_32.sv
//--------------------------------------------------
// main control decoder
// opcode in, datapath steering and illegal flag out
//--------------------------------------------------
module control_32 (
	input  logic [5:0] opcode,
	ctrl_if.decoder    ctrl
);

	always_comb begin
		// everything off unless the opcode asks for it
		ctrl.alu_op    = mips_pkg::ALU_MEM;
		ctrl.mem_toreg = 1'b0;
		ctrl.mem_write = 1'b0;
		ctrl.mem_read  = 1'b0;
		ctrl.branch    = 1'b0;
		ctrl.alu_src   = 1'b0;
		ctrl.reg_dst   = 1'b0;
		ctrl.reg_write = 1'b0;
		ctrl.jump      = 1'b0;
		ctrl.illegal   = 1'b0;

		case (opcode)
			mips_pkg::OP_RTYPE: begin
				ctrl.alu_op    = mips_pkg::ALU_ARITH;
				ctrl.reg_dst   = 1'b1; // write rd
				ctrl.reg_write = 1'b1;
			end

			mips_pkg::OP_LW: begin
				ctrl.alu_op    = mips_pkg::ALU_MEM;
				ctrl.mem_toreg = 1'b1;
				ctrl.mem_read  = 1'b1;
				ctrl.alu_src   = 1'b1;
				ctrl.reg_write = 1'b1;
			end

			mips_pkg::OP_SW: begin
				ctrl.alu_op    = mips_pkg::ALU_MEM;
				ctrl.mem_write = 1'b1;
				ctrl.alu_src   = 1'b1;
			end

			mips_pkg::OP_BEQ: begin
				ctrl.alu_op = mips_pkg::ALU_BEQ; // zero flag means equal
				ctrl.branch = 1'b1;
			end

			mips_pkg::OP_ADDI: begin
				ctrl.alu_op    = mips_pkg::ALU_MEM;
				ctrl.alu_src   = 1'b1;
				ctrl.reg_write = 1'b1;
			end

			mips_pkg::OP_J: begin
				ctrl.jump = 1'b1;
			end

			default: begin
				ctrl.illegal = 1'b1;
			end
		endcase
	end

	// one memory access per instruction, never a read and a write together
	always_comb begin
		a_no_rd_wr: assert final (!(ctrl.mem_read && ctrl.mem_write))
			else $error("control_32: mem_read and mem_write both high, opcode %b", opcode);
	end

endmodule

//--- hw/alu_32.sv
//--------------------------------------------------
// alu
// add, sub, and, or, slt with a zero flag
//--------------------------------------------------
module alu_32 (
	input  mips_pkg::alu_op_t alu_op,
	input  logic [5:0]        funct,
	input  logic [31:0]       a,
	input  logic [31:0]       b,
	output logic [31:0]       result,
	output logic              zero
);

	logic signed_lt;

	assign signed_lt = $signed(a) < $signed(b);

	always_comb begin
		result = '0;
		case (alu_op)
			mips_pkg::ALU_MEM: begin
				result = a + b; // lw, sw, addi
			end

			mips_pkg::ALU_BEQ: begin
				result = a - b;
			end

			mips_pkg::ALU_ARITH: begin
				case (funct)
					mips_pkg::FN_ADD: result = a + b;
					mips_pkg::FN_SUB: result = a - b;
					mips_pkg::FN_AND: result = a & b;
					mips_pkg::FN_OR:  result = a | b;
					mips_pkg::FN_SLT: result = {31'd0, signed_lt};
					default:          result = '0; // unknown funct
				endcase
			end

			default: begin
				result = '0;
			end
		endcase
	end

	assign zero = (result == 32'd0);

endmodule

//--- hw/reg_file_32.sv
//--------------------------------------------------
// register file
// 32x32, two async reads, one write, r0 tied to zero
//--------------------------------------------------
module reg_file_32 (
	input  logic        clk,
	input  logic        arst_n,
	input  logic [4:0]  ra1,
	input  logic [4:0]  ra2,
	output logic [31:0] rd1,
	output logic [31:0] rd2,
	input  logic        we,
	input  logic [4:0]  wa,
	input  logic [31:0] wd
);

	logic [31:0] regs [1:31]; // r0 has no storage

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wa != 5'd0) begin
			regs[wa] <= wd;
		end
	end

	assign rd1 = (ra1 == 5'd0) ? 32'd0 : regs[ra1];
	assign rd2 = (ra2 == 5'd0) ? 32'd0 : regs[ra2];

	a_r0_zero: assert property (@(posedge clk) disable iff (!arst_n)
		(ra1 == 5'd0) |-> (rd1 == 32'd0))
		else $error("reg_file_32: r0 read back nonzero");

endmodule

//--- hw/mem_32.sv
//--------------------------------------------------
// word ram
// async read, write on the edge; program and data
//--------------------------------------------------
module mem_32 #(
	parameter int depth = mips_pkg::IMEM_WORDS,
	parameter int aw    = mips_pkg::IMEM_AW
) (
	input  logic          clk,
	input  logic          arst_n,
	input  logic [aw-1:0] addr,
	output logic [31:0]   rdata,
	input  logic          we,
	input  logic [31:0]   wdata
);

	logic [31:0] mem [depth];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < depth; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			mem[addr] <= wdata;
		end
	end

	// addresses past depth read as zero
	assign rdata = (int'(addr) < depth) ? mem[addr] : 32'd0;

	a_wr_in_range: assert property (@(posedge clk) disable iff (!arst_n)
		we |-> (int'(addr) < depth))
		else $error("mem_32: write past end of array, addr %0d", addr);

endmodule

//--- hw/core_32.sv
//--------------------------------------------------
// datapath
// pc, halt, operand/writeback muxes and the
// load/peek access to both rams while stopped
//--------------------------------------------------
module core_32 (
	input  logic                          clk,
	input  logic                          arst_n,
	input  logic                          run,
	input  logic                          load_we,
	input  logic [mips_pkg::IMEM_AW-1:0]  load_addr,
	input  logic [31:0]                   load_data,
	input  logic [mips_pkg::DMEM_AW-1:0]  peek_addr,
	output logic [31:0]                   peek_data,
	output logic [5:0]                    opcode,
	ctrl_if.datapath                      ctrl,
	output logic [mips_pkg::IMEM_AW-1:0]  imem_addr,
	input  logic [31:0]                   imem_rdata,
	output logic                          imem_we,
	output logic [31:0]                   imem_wdata,
	output logic [mips_pkg::DMEM_AW-1:0]  dmem_addr,
	input  logic [31:0]                   dmem_rdata,
	output logic                          dmem_we,
	output logic [31:0]                   dmem_wdata,
	output logic [mips_pkg::IMEM_AW-1:0]  pc,
	output logic                          halted
);

	mips_pkg::instr_t instr;
	logic active;
	logic [31:0] imm_ext;
	logic [31:0] rd1;
	logic [31:0] rd2;
	logic [31:0] alu_b;
	logic [31:0] alu_result;
	logic alu_zero;
	logic [4:0] wa;
	logic [31:0] load_word;
	logic [31:0] wb_data;
	logic [mips_pkg::IMEM_AW-1:0] pc_inc;
	logic [mips_pkg::IMEM_AW-1:0] pc_next;

	assign active = run && !halted;

	// program ram: fetch while running, load port while stopped
	assign imem_addr  = run ? pc : load_addr;
	assign imem_we    = !run && load_we;
	assign imem_wdata = load_data;

	assign instr  = imem_rdata;
	assign opcode = instr.r.opcode;

	assign imm_ext = {{16{instr.i.imm[15]}}, instr.i.imm};
	assign alu_b   = ctrl.alu_src ? imm_ext : rd2;
	assign wa      = ctrl.reg_dst ? instr.r.rd : instr.r.rt;

	reg_file_32 rf_i (
		.clk    (clk),
		.arst_n (arst_n),
		.ra1    (instr.r.rs),
		.ra2    (instr.r.rt),
		.rd1    (rd1),
		.rd2    (rd2),
		.we     (active && ctrl.reg_write),
		.wa     (wa),
		.wd     (wb_data)
	);

	alu_32 alu_i (
		.alu_op (ctrl.alu_op),
		.funct  (instr.r.funct),
		.a      (rd1),
		.b      (alu_b),
		.result (alu_result),
		.zero   (alu_zero)
	);

	// lw/sw addresses are byte addresses, the ram is word indexed
	assign dmem_addr  = run ? alu_result[mips_pkg::DMEM_AW+1:2] : peek_addr;
	assign dmem_we    = active && ctrl.mem_write;
	assign dmem_wdata = rd2;
	assign peek_data  = dmem_rdata;

	assign load_word = ctrl.mem_read ? dmem_rdata : 32'd0;
	assign wb_data   = ctrl.mem_toreg ? load_word : alu_result;

	// pc counts words, branch offset is in words too
	assign pc_inc = pc + 1'b1;

	always_comb begin
		pc_next = pc_inc;
		if (ctrl.jump) begin
			pc_next = instr.j.target[mips_pkg::IMEM_AW-1:0];
		end else if (ctrl.branch && alu_zero) begin
			pc_next = pc_inc + imm_ext[mips_pkg::IMEM_AW-1:0];
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc     <= '0;
			halted <= 1'b0;
		end else if (active) begin
			if (ctrl.illegal) begin
				halted <= 1'b1; // pc stays on the bad word
			end else begin
				pc <= pc_next;
			end
		end
	end

	a_pc_hold: assert property (@(posedge clk) disable iff (!arst_n)
		!run |=> $stable(pc))
		else $error("core_32: pc moved while run was low");

endmodule

//--- hw/mips_top.sv
//--------------------------------------------------
// mips top
// decoder, datapath, program and data ram
//--------------------------------------------------
module mips_top (
	input  logic                          clk,
	input  logic                          arst_n,
	input  logic                          run,
	input  logic                          load_we,
	input  logic [mips_pkg::IMEM_AW-1:0]  load_addr,
	input  logic [31:0]                   load_data,
	input  logic [mips_pkg::DMEM_AW-1:0]  peek_addr,
	output logic [31:0]                   peek_data,
	output logic [mips_pkg::IMEM_AW-1:0]  pc,
	output logic                          halted
);

	ctrl_if ctrl_bus ();

	logic [5:0] opcode;
	logic [mips_pkg::IMEM_AW-1:0] imem_addr;
	logic [31:0] imem_rdata;
	logic imem_we;
	logic [31:0] imem_wdata;
	logic [mips_pkg::DMEM_AW-1:0] dmem_addr;
	logic [31:0] dmem_rdata;
	logic dmem_we;
	logic [31:0] dmem_wdata;

	control_32 ctrl_i (
		.opcode (opcode),
		.ctrl   (ctrl_bus)
	);

	core_32 core_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.run        (run),
		.load_we    (load_we),
		.load_addr  (load_addr),
		.load_data  (load_data),
		.peek_addr  (peek_addr),
		.peek_data  (peek_data),
		.opcode     (opcode),
		.ctrl       (ctrl_bus),
		.imem_addr  (imem_addr),
		.imem_rdata (imem_rdata),
		.imem_we    (imem_we),
		.imem_wdata (imem_wdata),
		.dmem_addr  (dmem_addr),
		.dmem_rdata (dmem_rdata),
		.dmem_we    (dmem_we),
		.dmem_wdata (dmem_wdata),
		.pc         (pc),
		.halted     (halted)
	);

	mem_32 #(.depth(mips_pkg::IMEM_WORDS), .aw(mips_pkg::IMEM_AW)) imem_i (
		.clk    (clk),
		.arst_n (arst_n),
		.addr   (imem_addr),
		.rdata  (imem_rdata),
		.we     (imem_we),
		.wdata  (imem_wdata)
	);

	mem_32 #(.depth(mips_pkg::DMEM_WORDS), .aw(mips_pkg::DMEM_AW)) dmem_i (
		.clk    (clk),
		.arst_n (arst_n),
		.addr   (dmem_addr),
		.rdata  (dmem_rdata),
		.we     (dmem_we),
		.wdata  (dmem_wdata)
	);

endmodule

//--- include/tb_prog.svh
//--------------------------------------------------
// program helpers
// instruction encoders and a loader that drives the
// load port of the testbench
//--------------------------------------------------
`ifndef TB_PROG_SVH
`define TB_PROG_SVH

// R-type word for rd = rs funct rt
function automatic logic [31:0] enc_r(input logic [5:0] funct, input logic [4:0] rd,
	input logic [4:0] rs, input logic [4:0] rt);
	mips_pkg::instr_t w;
	w.r.opcode = mips_pkg::OP_RTYPE;
	w.r.rs     = rs;
	w.r.rt     = rt;
	w.r.rd     = rd;
	w.r.shamt  = 5'd0;
	w.r.funct  = funct;
	return w;
endfunction

// I-type word with imm as a byte offset for lw/sw and a word offset for beq
function automatic logic [31:0] enc_i(input logic [5:0] opcode, input logic [4:0] rt,
	input logic [4:0] rs, input logic [15:0] imm);
	mips_pkg::instr_t w;
	w.i.opcode = opcode;
	w.i.rs     = rs;
	w.i.rt     = rt;
	w.i.imm    = imm;
	return w;
endfunction

function automatic logic [31:0] enc_j(input logic [25:0] target);
	mips_pkg::instr_t w;
	w.j.opcode = mips_pkg::OP_J;
	w.j.target = target; // word index
	return w;
endfunction

// writes prog into program ram while run is low
// uses clk and drives load_we, load_addr and load_data of the enclosing module
task automatic load_prog(input logic [31:0] prog []);
	foreach (prog[i]) begin
		@(negedge clk);
		load_we   = 1'b1;
		load_addr = i[mips_pkg::IMEM_AW-1:0];
		load_data = prog[i];
	end
	@(negedge clk);
	load_we = 1'b0;
endtask

`endif

//--- tests/tb_mips.sv
//--------------------------------------------------
// mips testbench
// directed programs go in through the load port and
// results come back through the peek port
//--------------------------------------------------
module tb_mips;

	logic clk;
	logic arst_n;
	logic run;
	logic load_we;
	logic [mips_pkg::IMEM_AW-1:0] load_addr;
	logic [31:0] load_data;
	logic [mips_pkg::DMEM_AW-1:0] peek_addr;
	logic [31:0] peek_data;
	logic [mips_pkg::IMEM_AW-1:0] pc;
	logic halted;

	int check_errors = 0;
	int timeouts = 0;
	logic [31:0] prog_q [$];

	`include "tb_prog.svh"

	mips_top dut_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.run       (run),
		.load_we   (load_we),
		.load_addr (load_addr),
		.load_data (load_data),
		.peek_addr (peek_addr),
		.peek_data (peek_data),
		.pc        (pc),
		.halted    (halted)
	);

	always #2 clk = ~clk;

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
			check_errors++;
		end
	endtask

	task automatic apply_reset();
		@(negedge clk);
		arst_n = 1'b0;
		repeat (5) @(negedge clk);
		arst_n = 1'b1;
	endtask

	task automatic check_peek(input int idx, input logic [31:0] exp);
		@(negedge clk);
		peek_addr = idx[mips_pkg::DMEM_AW-1:0];
		#1;
		check_eq($sformatf("dmem[%0d]", idx), peek_data, exp);
	endtask

	// raise run and wait for the halt on the closing illegal word
	task automatic run_prog();
		int cycles;
		cycles = 0;
		@(negedge clk);
		run = 1'b1;
		while (!halted && cycles < 200) begin
			@(negedge clk);
			cycles++;
		end
		if (!halted) begin
			$display("timeout at %0t: core did not halt within %0d cycles", $time, cycles);
			timeouts++;
		end
		run = 1'b0;
	endtask

	// reset clears both rams, so every program starts from a clean core
	task automatic start_prog();
		apply_reset();
		prog_q.delete();
	endtask

	task automatic finish_prog();
		logic [31:0] words [];
		prog_q.push_back(32'hfc00_0000); // opcode 6'b111111 is not supported
		words = new[prog_q.size()];
		foreach (prog_q[i]) words[i] = prog_q[i];
		load_prog(words);
	endtask

	task automatic test_reset();
		apply_reset();
		check_eq("pc", pc, 0);
		check_eq("halted", halted, 0);
	endtask

	task automatic test_arith();
		logic [15:0] a;
		logic [15:0] b;
		logic [31:0] sa;
		logic [31:0] sb;
		a = $urandom();
		b = $urandom();
		sa = {{16{a[15]}}, a};
		sb = {{16{b[15]}}, b};
		start_prog();
		prog_q.push_back(enc_i(mips_pkg::OP_ADDI, 5'd1, 5'd0, a));
		prog_q.push_back(enc_i(mips_pkg::OP_ADDI, 5'd2, 5'd0, b));
		prog_q.push_back(enc_r(mips_pkg::FN_ADD, 5'd3, 5'd1, 5'd2));
		prog_q.push_back(enc_r(mips_pkg::FN_SUB, 5'd4, 5'd1, 5'd2));
		prog_q.push_back(enc_r(mips_pkg::FN_AND, 5'd5, 5'd1, 5'd2));
		prog_q.push_back(enc_r(mips_pkg::FN_OR, 5'd6, 5'd1, 5'd2));
		prog_q.push_back(enc_r(mips_pkg::FN_SLT, 5'd7, 5'd1, 5'd2));
		for (int r = 3; r <= 7; r++) begin
			prog_q.push_back(enc_i(mips_pkg::OP_SW, r[4:0], 5'd0, 16'((r - 3) * 4)));
		end
		finish_prog();
		run_prog();
		check_peek(0, sa + sb);
		check_peek(1, sa - sb);
		check_peek(2, sa & sb);
		check_peek(3, sa | sb);
		check_peek(4, ($signed(sa) < $signed(sb)) ? 32'd1 : 32'd0);
	endtask

	task automatic test_mem();
		logic [15:0] hi;
		logic [15:0] lo;
		logic [31:0] w;
		hi = $urandom();
		lo = $urandom();
		w = {hi, 16'h0000} + {{16{lo[15]}}, lo};
		start_prog();
		prog_q.push_back(enc_i(mips_pkg::OP_ADDI, 5'd1, 5'd0, hi));
		// sixteen doublings move hi into the upper half
		repeat (16) prog_q.push_back(enc_r(mips_pkg::FN_ADD, 5'd1, 5'd1, 5'd1));
		prog_q.push_back(enc_i(mips_pkg::OP_ADDI, 5'd1, 5'd1, lo));
		prog_q.push_back(enc_i(mips_pkg::OP_SW, 5'd1, 5'd0, 16'd0));
		prog_q.push_back(enc_i(mips_pkg::OP_LW, 5'd2, 5'd0, 16'd0));
		prog_q.push_back(enc_i(mips_pkg::OP_SW, 5'd2, 5'd0, 16'd4));
		finish_prog();
		run_prog();
		check_peek(0, w);
		check_peek(1, w);
	endtask

	task automatic test_flow();
		start_prog();
		prog_q.push_back(enc_i(mips_pkg::OP_ADDI, 5'd1, 5'd0, 16'd5));
		prog_q.push_back(enc_i(mips_pkg::OP_ADDI, 5'd2, 5'd0, 16'd5));
		prog_q.push_back(enc_i(mips_pkg::OP_ADDI, 5'd3, 5'd0, 16'd7));
		prog_q.push_back(enc_i(mips_pkg::OP_ADDI, 5'd4, 5'd0, 16'h55));
		prog_q.push_back(enc_i(mips_pkg::OP_BEQ, 5'd2, 5'd1, 16'd1)); // taken
		prog_q.push_back(enc_i(mips_pkg::OP_SW, 5'd4, 5'd0, 16'd0));
		prog_q.push_back(enc_i(mips_pkg::OP_BEQ, 5'd3, 5'd1, 16'd1)); // not taken
		prog_q.push_back(enc_i(mips_pkg::OP_SW, 5'd4, 5'd0, 16'd4));
		prog_q.push_back(enc_j(26'd10));
		prog_q.push_back(enc_i(mips_pkg::OP_SW, 5'd4, 5'd0, 16'd8));
		prog_q.push_back(enc_i(mips_pkg::OP_SW, 5'd4, 5'd0, 16'd12)); // jump lands here
		finish_prog();
		run_prog();
		check_peek(0, 32'd0);
		check_peek(1, 32'h55);
		check_peek(2, 32'd0);
		check_peek(3, 32'h55);
	endtask

	task automatic test_illegal();
		start_prog();
		prog_q.push_back(enc_i(mips_pkg::OP_ADDI, 5'd1, 5'd0, 16'h33));
		prog_q.push_back(enc_i(mips_pkg::OP_SW, 5'd1, 5'd0, 16'd0));
		prog_q.push_back(32'hfc00_0000); // illegal word at index 2
		prog_q.push_back(enc_i(mips_pkg::OP_SW, 5'd1, 5'd0, 16'd4)); // store behind the halt
		finish_prog();
		run_prog();
		// run stays high on the halted core so pc and dmem must hold
		@(negedge clk);
		run = 1'b1;
		repeat (3) @(negedge clk);
		run = 1'b0;
		check_eq("pc", pc, 2);
		check_eq("halted", halted, 1);
		check_peek(0, 32'h33);
		check_peek(1, 32'd0);
	endtask

	task automatic test_stall();
		logic [mips_pkg::IMEM_AW-1:0] held_pc;
		start_prog();
		prog_q.push_back(enc_i(mips_pkg::OP_ADDI, 5'd1, 5'd0, 16'h1234));
		prog_q.push_back(enc_i(mips_pkg::OP_SW, 5'd1, 5'd0, 16'd0));
		repeat (8) prog_q.push_back(enc_i(mips_pkg::OP_ADDI, 5'd2, 5'd2, 16'd1));
		prog_q.push_back(enc_i(mips_pkg::OP_SW, 5'd2, 5'd0, 16'd4));
		finish_prog();
		@(negedge clk);
		run = 1'b1;
		repeat (4) @(negedge clk);
		run = 1'b0;
		held_pc = pc;
		check_eq("pc", held_pc, 4);
		repeat (5) @(negedge clk);
		check_eq("pc", pc, held_pc);
		check_peek(0, 32'h1234);
		run_prog();
		check_eq("pc", pc, 11);
		check_peek(1, 32'd8);
	endtask

	initial begin
		clk = 1'b0;
		arst_n = 1'b0;
		run = 1'b0;
		load_we = 1'b0;
		load_addr = '0;
		load_data = '0;
		peek_addr = '0;
		void'($urandom(32'hf38));
		test_reset();
		test_arith();
		test_mem();
		test_flow();
		test_illegal();
		test_stall();
		$display("summary: %0d check errors, %0d timeouts", check_errors, timeouts);
		if (check_errors == 0 && timeouts == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

//--- all.f
+incdir+include
hw/mips_pkg.sv
hw/ctrl_if.sv
hw/control_32.sv
hw/alu_32.sv
hw/reg_file_32.sv
hw/mem_32.sv
hw/core_32.sv
hw/mips_top.sv
tests/tb_mips.sv
